// File: src.f
src/softplus_pkg.sv
src/pipe_if.sv
src/segment_select.sv
src/sm_multiply.sv
src/sm_add.sv
src/softplus_pipe.sv
src/softplus_wb_slave.sv
src/softplus_top.sv
testbench/softplus_assertions.sv
testbench/tb_softplus.sv

// File: Makefile
TOP := tb_softplus

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_softplus.sv
/* softplus accelerator testbench
   stimulus table, reference model, Wishbone driver, cycle watchdog */
`timescale 1ns/1ps

module tb_softplus;
    import softplus_pkg::*;

    typedef struct packed {
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
        logic [31:0] exp;       // checked on reads only
    } row_t;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    row_t   rows[$];            // stimulus table
    fixed_t last_op;            // operand of the latest launch
    int     checks;
    int     errors;
    int     cycles;
    int     limit;

    softplus_top DUT (
        .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period
    end

    // sign-magnitude to plain integer with -0 as 0
    function automatic longint sm_to_int(input fixed_t v);
        longint mag;
        mag = longint'(v[22:0]);
        return v[23] ? -mag : mag;
    endfunction

    // integer back to clipped sign-magnitude
    function automatic fixed_t int_to_sm(input longint v);
        longint mag;
        mag = (v < 0) ? -v : v;
        if (mag > longint'(MAG_MAX)) begin
            mag = longint'(MAG_MAX);
        end
        return {(v < 0) && (mag != 0), mag[22:0]};
    endfunction

    // expected output from strict segment compare, truncated product and signed sum
    function automatic fixed_t softplus_model(input fixed_t x);
        seg_idx_t seg;
        longint   pmag;
        longint   prod;
        seg = '0;
        for (int i = 0; i < NUM_BREAKS; i++) begin
            if (sm_to_int(x) > sm_to_int(BREAKS[i])) begin
                seg++;
            end
        end
        pmag = (longint'(x[22:0]) * longint'(SLOPES[seg][22:0])) >> FRAC_BITS;
        if (pmag > longint'(MAG_MAX)) begin
            pmag = longint'(MAG_MAX);
        end
        prod = (x[23] ^ SLOPES[seg][23]) ? -pmag : pmag;
        return int_to_sm(prod + sm_to_int(INTERCEPTS[seg]));
    endfunction

    task automatic add_row(input logic we, input logic [1:0] adr,
                           input logic [31:0] dat, input logic [31:0] exp);
        rows.push_back({we, adr, dat, exp});
    endtask

    // launch write followed by a result read
    task automatic add_eval(input logic [31:0] dat);
        last_op = dat[23:0];                    // upper byte ignored by the slave
        add_row(1'b1, 2'd0, dat, 32'h0);
        add_row(1'b0, 2'd1, 32'h0, {8'h00, softplus_model(last_op)});
    endtask

    task automatic build_table();
        longint mid;
        add_row(1'b0, 2'd1, 32'h0, 32'h0);     // result after reset
        add_row(1'b0, 2'd0, 32'h0, 32'h0);     // operand after reset
        for (int s = 0; s < NUM_SEGS; s++) begin
            if (s == 0) begin
                mid = sm_to_int(BREAKS[0]) - 32768;    // 1.0 below the first break
            end else if (s == NUM_SEGS - 1) begin
                mid = sm_to_int(BREAKS[NUM_BREAKS-1]) + 32768;
            end else begin
                mid = (sm_to_int(BREAKS[s-1]) + sm_to_int(BREAKS[s])) / 2;
            end
            add_eval({8'h00, int_to_sm(mid)});
        end
        for (int i = 0; i < NUM_BREAKS; i++) begin
            add_eval({8'h00, BREAKS[i]});     // on the break selects the lower segment
        end
        add_row(1'b1, 2'd0, 32'h0080_0000, 32'h0);     // negative zero
        add_row(1'b0, 2'd1, 32'h0, {8'h00, softplus_model(24'h000000)});
        add_eval(32'h00ff_ffff);                // most negative
        add_eval(32'h007f_ffff);                // most positive
        add_eval(32'h0084_0000);                // -8.0 in the far left tail
        add_eval(32'h0004_0000);                // +8.0
        add_row(1'b0, 2'd0, 32'h0, {8'h00, last_op});
        add_row(1'b0, 2'd2, 32'h0, 32'h0);
        add_row(1'b0, 2'd3, 32'h0, 32'h0);
        add_row(1'b1, 2'd1, 32'hdead_beef, 32'h0);     // result is read-only
        add_row(1'b1, 2'd2, 32'h1234_5678, 32'h0);
        add_row(1'b1, 2'd3, 32'h8765_4321, 32'h0);
        add_row(1'b0, 2'd1, 32'h0, {8'h00, softplus_model(last_op)});
        add_row(1'b0, 2'd0, 32'h0, {8'h00, last_op});
        repeat (12) begin
            add_eval($urandom());
        end
    endtask

    // one classic cycle with stb held through the acknowledging edge
    task automatic bus_cycle(input row_t r, output logic [31:0] rdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = r.we;
        wb_adr   = r.adr;
        wb_dat_w = r.dat;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        void'($urandom(32'h3331_940f));        // seed once
        checks   = 0;
        errors   = 0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 2'd0;
        wb_dat_w = 32'h0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            bus_cycle(rows[i], rdata);
            if (rows[i].we) begin
                $display("row %0d: write adr %0d data %h acked", i, rows[i].adr, rows[i].dat);
            end else begin
                checks++;
                if (rdata !== rows[i].exp) begin
                    errors++;
                    $display("[ERROR] t=%0t row %0d wb_dat_r expected %h actual %h",
                             $time, i, rows[i].exp, rdata);
                end else begin
                    $display("row %0d: read adr %0d = %h ok", i, rows[i].adr, rdata);
                end
            end
        end
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog started once the table is built
    initial begin
        cycles = 0;
        @(posedge clk);
        limit = rows.size() * 10 + 50;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no acknowledge within %0d cycles", limit);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: testbench/softplus_assertions.sv
/* concurrent checks bound into softplus_top
   Wishbone ack handshake, pipeline launch-to-result timing */
`timescale 1ns/1ps

module softplus_assertions (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic x_valid,
    input logic y_valid
);
    import softplus_pkg::*;

    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))          // ack only inside a live request
        else $error("wb_ack high outside wb_cyc/wb_stb");

    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)                     // one-cycle pulse
        else $error("wb_ack high on two consecutive cycles");

    // result tag trails the launch tag by the pipe depth
    pipe_latency: assert property (@(posedge clk) disable iff (reset)
        y_valid == $past(x_valid, LATENCY))
        else $error("y_valid not LATENCY cycles after x_valid");

endmodule

bind softplus_top softplus_assertions u_assertions (
    .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .x_valid(pif.x_valid), .y_valid(pif.y_valid)
);

// File: src/softplus_top.sv
/* softplus accelerator top level
   Wishbone slave and softplus pipeline joined by pipe_if */
`timescale 1ns/1ps

module softplus_top (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    pipe_if pif ();     // slave <-> datapath

    softplus_wb_slave u_slave (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .pif      (pif.master)
    );

    softplus_pipe u_pipe (.clk(clk), .reset(reset), .pif(pif.pipe));

endmodule

// File: src/softplus_wb_slave.sv
/* Wishbone classic slave for the softplus accelerator
   operand/result registers, launch FSM, single-cycle reads */
`timescale 1ns/1ps

module softplus_wb_slave (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    pipe_if.master      pif
);
    import softplus_pkg::*;

    typedef enum logic [1:0] {idle, wait_result, ack} state_t;

    state_t      state;
    fixed_t      operand;       // addr 0
    fixed_t      result;        // addr 1
    logic        req;           // fresh request, not the acked one
    logic [31:0] rd_data;

    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign pif.x = operand;

    always_comb begin
        case (wb_adr)
            2'd0:    rd_data = {8'h00, operand};
            2'd1:    rd_data = {8'h00, result};
            default: rd_data = 32'h0;           // 2 and 3 unmapped
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= idle;
            operand     <= '0;
            result      <= '0;
            wb_dat_r    <= '0;
            wb_ack      <= 1'b0;
            pif.x_valid <= 1'b0;
        end else begin
            wb_ack      <= 1'b0;                // single-cycle pulses
            pif.x_valid <= 1'b0;
            case (state)
                idle: begin
                    if (req && wb_we && wb_adr == 2'd0) begin
                        operand     <= wb_dat_w[23:0];  // launch
                        pif.x_valid <= 1'b1;
                        state       <= wait_result;
                    end else if (req) begin
                        wb_ack <= 1'b1;         // reads and dead writes
                        if (!wb_we) begin
                            wb_dat_r <= rd_data;
                        end
                    end
                end
                wait_result: begin
                    if (pif.y_valid) begin
                        result <= pif.y;
                        wb_ack <= 1'b1;
                        state  <= ack;
                    end
                end
                ack:     state <= idle;         // ack is high here
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: src/softplus_pipe.sv
/* three-stage softplus datapath
   segment select, multiply, product/intercept register, add, valid tag */
`timescale 1ns/1ps

module softplus_pipe (
    input  logic clk,
    input  logic reset,
    pipe_if.pipe pif
);
    import softplus_pkg::*;

    fixed_t slope;          // from segment_select, 2 edges after x
    fixed_t intercept;
    fixed_t x_d1;           // operand delay line
    fixed_t x_d2;
    fixed_t product;        // comb multiply
    fixed_t product_q;      // stage 3
    fixed_t intercept_q;
    fixed_t sum;
    logic [LATENCY-1:0] vld;    // valid tag shift register

    segment_select u_select (
        .clk       (clk),
        .reset     (reset),
        .x         (pif.x),
        .slope     (slope),
        .intercept (intercept)
    );

    sm_multiply u_mul (.a(x_d2), .b(slope), .p(product));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x_d1        <= '0;
            x_d2        <= '0;
            product_q   <= '0;
            intercept_q <= '0;
            vld         <= '0;
        end else begin
            x_d1        <= pif.x;
            x_d2        <= x_d1;            // meets slope at edge 2
            product_q   <= product;         // edge 3
            intercept_q <= intercept;
            vld         <= {vld[LATENCY-2:0], pif.x_valid};
        end
    end

    sm_add u_add (.a(product_q), .b(intercept_q), .s(sum));

    assign pif.y       = sum;               // add is after the last register
    assign pif.y_valid = vld[LATENCY-1];

endmodule

// File: src/sm_add.sv
/* combinational sign-magnitude fixed-point add
   same signs add with saturation, mixed signs subtract smaller from larger */
`timescale 1ns/1ps

module sm_add (
    input  softplus_pkg::fixed_t a,
    input  softplus_pkg::fixed_t b,
    output softplus_pkg::fixed_t s
);
    import softplus_pkg::*;

    logic [23:0] sum;       // magnitude sum plus carry
    logic [22:0] diff;      // larger minus smaller
    logic        a_big;     // |a| >= |b|
    logic [22:0] mag;
    logic        sign;

    assign a_big = a[22:0] >= b[22:0];
    assign sum   = {1'b0, a[22:0]} + {1'b0, b[22:0]};
    assign diff  = a_big ? (a[22:0] - b[22:0]) : (b[22:0] - a[22:0]);

    always_comb begin
        if (a[23] == b[23]) begin
            mag  = sum[23] ? MAG_MAX : sum[22:0];   // carry out -> clip
            sign = a[23];
        end else begin
            mag  = diff;
            sign = a_big ? a[23] : b[23];           // larger operand wins
        end
    end

    // equal magnitudes of opposite sign give +0
    assign s = {sign && (mag != '0), mag};

endmodule

// File: src/sm_multiply.sv
/* combinational sign-magnitude fixed-point multiply
   truncating shift by the fraction width, saturating magnitude */
`timescale 1ns/1ps

module sm_multiply (
    input  softplus_pkg::fixed_t a,
    input  softplus_pkg::fixed_t b,
    output softplus_pkg::fixed_t p
);
    import softplus_pkg::*;

    logic [45:0] prod_full;     // 23 x 23 magnitude product
    logic [45:0] prod_shr;      // back to q8.15, truncated
    logic [22:0] mag;
    logic        sign;

    assign prod_full = {23'b0, a[22:0]} * {23'b0, b[22:0]};
    assign prod_shr  = prod_full >> FRAC_BITS;

    always_comb begin
        if (|prod_shr[45:23]) begin
            mag = MAG_MAX;              // clip on overflow
        end else begin
            mag = prod_shr[22:0];
        end
    end

    assign sign = a[23] ^ b[23];

    // no negative zero on the output
    assign p = {sign && (mag != '0), mag};

endmodule

// File: src/segment_select.sv
/* segment selector for the softplus pipe
   breakpoint compare, registered index, registered slope/intercept lookup */
`timescale 1ns/1ps

module segment_select (
    input  logic                 clk,
    input  logic                 reset,
    input  softplus_pkg::fixed_t x,
    output softplus_pkg::fixed_t slope,
    output softplus_pkg::fixed_t intercept
);
    import softplus_pkg::*;

    seg_idx_t seg_comb;     // breakpoints strictly below x
    seg_idx_t seg_q;        // stage 1 index

    // sign-magnitude to two's complement, -0 lands on 0
    function automatic logic signed [23:0] to_int(input fixed_t v);
        logic signed [23:0] mag;
        mag = {1'b0, v[22:0]};
        return v[23] ? -mag : mag;
    endfunction

    always_comb begin
        seg_comb = '0;
        for (int i = 0; i < NUM_BREAKS; i++) begin
            if (to_int(x) > to_int(BREAKS[i])) begin  // on a break -> lower seg
                seg_comb = seg_comb + 1'b1;
            end
        end
    end

    // stage 1: index
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seg_q <= '0;
        end else begin
            seg_q <= seg_comb;
        end
    end

    // stage 2: table lookup, lines up with the twice-delayed operand
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            slope     <= '0;
            intercept <= '0;
        end else begin
            slope     <= SLOPES[seg_q];
            intercept <= INTERCEPTS[seg_q];
        end
    end

endmodule

// File: src/pipe_if.sv
/* bus slave to softplus pipeline link
   operand with valid pulse out, result with valid pulse back */
`timescale 1ns/1ps

interface pipe_if;
    import softplus_pkg::*;

    fixed_t x;          // operand
    logic   x_valid;    // one-cycle launch pulse
    fixed_t y;          // result
    logic   y_valid;    // pulses LATENCY edges after x_valid

    // slave side launches, pipe side answers
    modport master (output x, output x_valid, input y, input y_valid);
    modport pipe (input x, input x_valid, output y, output y_valid);

endinterface

// File: src/softplus_pkg.sv
/* softplus accelerator shared definitions
   sign-magnitude fixed-point type, format constants, segment tables */
package softplus_pkg;

    localparam int FRAC_BITS  = 15;              // q8.15 magnitude
    localparam int NUM_BREAKS = 8;               // breakpoints between segments
    localparam int NUM_SEGS   = NUM_BREAKS + 1;  // 9 linear pieces
    localparam int LATENCY    = 3;               // edges from pipe x to pipe y

    typedef logic [23:0] fixed_t;                    // [23] sign, [22:0] magnitude
    typedef logic [$clog2(NUM_SEGS)-1:0] seg_idx_t;  // 0 .. 8

    localparam logic [22:0] MAG_MAX = 23'h7f_ffff;   // saturation ceiling

    // ascending, symmetric about zero
    localparam fixed_t BREAKS [NUM_BREAKS] = '{
        24'h81f1f0,     // -3.890
        24'h8123bd,     // -2.279
        24'h809de1,     // -1.233
        24'h8032aa,     // -0.396
        24'h003263,     // 0.394
        24'h009d89,     // 1.231
        24'h012443,     // 2.283
        24'h01f1df      // 3.890
    };

    localparam fixed_t SLOPES [NUM_SEGS] = '{
        24'h00009e,     // 0.0048, far left tail
        24'h000622,     // 0.0479
        24'h00135c,     // 0.1513
        24'h002796,     // 0.3093
        24'h003ff7,     // 0.4997, around zero
        24'h005859,     // 0.6902
        24'h006ca4,     // 0.8488
        24'h0079e0,     // 0.9522
        24'h007f61      // 0.9952, nearly identity
    };

    localparam fixed_t INTERCEPTS [NUM_SEGS] = '{
        24'h000500,     // 0.0391
        24'h001a75,     // 0.2067
        24'h00389a,     // 0.4422
        24'h00518c,     // 0.6371
        24'h005b33,     // 0.7125, peak at centre
        24'h005199,     // 0.6375
        24'h00389f,     // 0.4424
        24'h001a67,     // 0.2063
        24'h000500      // 0.0391
    };

endpackage
